// ==== verilog/idiv_defs.svh ====
`ifndef IDIV_DEFS_SVH
`define IDIV_DEFS_SVH

// operand and result width of the divider
`define IDIV_WIDTH 32

// iteration counter width, wide enough to count IDIV_WIDTH+1 steps
`define IDIV_CNT_W 6

`endif

// ==== verilog/idiv_pkg.sv ====
`include "idiv_defs.svh"

package idiv_pkg;

  typedef logic [`IDIV_WIDTH-1:0] word_t;
  // operand registers and adder carry one extra sign bit on top
  typedef logic [`IDIV_WIDTH:0]   ext_t;
  typedef logic [`IDIV_CNT_W-1:0] count_t;

  // one-hot mux selects
  typedef logic [1:0] a_sel_t;
  typedef logic [2:0] bc_sel_t;

  localparam a_sel_t  A_SEL_DIVISOR  = 2'b01;
  localparam a_sel_t  A_SEL_ADDER    = 2'b10;
  localparam bc_sel_t B_SEL_C        = 3'b001;
  localparam bc_sel_t B_SEL_ADDER    = 3'b010;
  localparam bc_sel_t B_SEL_SHIFT    = 3'b100;
  localparam bc_sel_t C_SEL_DIVIDEND = 3'b001;
  localparam bc_sel_t C_SEL_ADDER    = 3'b010;
  localparam bc_sel_t C_SEL_SHIFT    = 3'b100;

  typedef enum logic [3:0] {
    IDLE,
    NEG_DIVISOR,
    NEG_DIVIDEND,
    SHIFT,
    ITERATE,
    REPAIR,
    NEG_REM,
    NEG_QUOT,
    DONE
  } state_e;

endpackage

// ==== verilog/idiv_datapath.sv ====
`timescale 1ns/1ps
`include "idiv_defs.svh"

module idiv_datapath (
  input  logic              clk_i,
  input  idiv_pkg::word_t   dividend_i,
  input  idiv_pkg::word_t   divisor_i,
  input  logic              signed_div_i,

  input  idiv_pkg::a_sel_t  a_sel_i,
  input  logic              a_ld_i,
  input  logic              a_inv_i,
  input  logic              a_clr_n_i,

  input  idiv_pkg::bc_sel_t b_sel_i,
  input  logic              b_ld_i,
  input  logic              b_inv_i,
  input  logic              b_clr_n_i,

  input  idiv_pkg::bc_sel_t c_sel_i,
  input  logic              c_ld_i,
  input  logic              sign_ld_i,
  input  logic              adder_cin_i,

  output logic              zero_divisor_o,
  output logic              signed_div_o,
  output logic              adder_neg_o,
  output logic              a_neg_o,
  output logic              c_neg_o,

  output idiv_pkg::word_t   quotient_o,
  output idiv_pkg::word_t   remainder_o
);

  localparam int W = `IDIV_WIDTH;

  idiv_pkg::ext_t a_r, b_r, c_r;
  idiv_pkg::ext_t a_mux, b_mux, c_mux;
  idiv_pkg::ext_t divisor_ext, dividend_ext;
  idiv_pkg::ext_t add_a, add_b, adder_out;
  logic           signed_r;

  // sign extension only applies to signed requests
  assign divisor_ext  = {signed_div_i & divisor_i[W-1], divisor_i};
  assign dividend_ext = {signed_div_i & dividend_i[W-1], dividend_i};

  // ------------------------------------------------------------
  // adder with invert and clear on both inputs
  // ------------------------------------------------------------
  assign add_a = (a_r ^ {(W+1){a_inv_i}}) & {(W+1){a_clr_n_i}};
  assign add_b = (b_r ^ {(W+1){b_inv_i}}) & {(W+1){b_clr_n_i}};
  assign adder_out = add_a + add_b + idiv_pkg::ext_t'(adder_cin_i);

  // ------------------------------------------------------------
  // one-hot operand muxes
  // ------------------------------------------------------------
  assign a_mux = ({(W+1){a_sel_i[0]}} & divisor_ext)
               | ({(W+1){a_sel_i[1]}} & adder_out);

  // B: copy of C, plain sum, or sum shifted with the next dividend bit
  assign b_mux = ({(W+1){b_sel_i[0]}} & c_r)
               | ({(W+1){b_sel_i[1]}} & adder_out)
               | ({(W+1){b_sel_i[2]}} & {adder_out[W-1:0], c_r[W]});

  // C: dividend, sum, or shift in the new quotient bit
  assign c_mux = ({(W+1){c_sel_i[0]}} & dividend_ext)
               | ({(W+1){c_sel_i[1]}} & adder_out)
               | ({(W+1){c_sel_i[2]}} & {c_r[W-1:0], ~adder_out[W]});

  always_ff @(posedge clk_i) begin
    if (a_ld_i) begin
      a_r <= a_mux;
    end
    if (b_ld_i) begin
      b_r <= b_mux;
    end
    if (c_ld_i) begin
      c_r <= c_mux;
    end
    if (sign_ld_i) begin
      signed_r <= signed_div_i;
    end
  end

  // status back to the controller
  assign zero_divisor_o = ~(|a_r);
  assign signed_div_o   = signed_r;
  assign adder_neg_o    = adder_out[W];
  assign a_neg_o        = a_r[W];
  assign c_neg_o        = c_r[W];

  // A ends as the remainder, C as the quotient
  assign remainder_o = a_r[W-1:0];
  assign quotient_o  = c_r[W-1:0];

endmodule

// ==== verilog/idiv_controller.sv ====
`timescale 1ns/1ps
`include "idiv_defs.svh"

module idiv_controller (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              v_i,
  input  logic              yumi_i,

  input  logic              zero_divisor_i,
  input  logic              signed_div_i,
  input  logic              adder_neg_i,
  input  logic              a_neg_i,
  input  logic              c_neg_i,

  output logic              ready_and_o,
  output logic              v_o,

  output idiv_pkg::a_sel_t  a_sel_o,
  output logic              a_ld_o,
  output logic              a_inv_o,
  output logic              a_clr_n_o,
  output idiv_pkg::bc_sel_t b_sel_o,
  output logic              b_ld_o,
  output logic              b_inv_o,
  output logic              b_clr_n_o,
  output idiv_pkg::bc_sel_t c_sel_o,
  output logic              c_ld_o,
  output logic              sign_ld_o,
  output logic              adder_cin_o
);

  idiv_pkg::state_e state_r, state_d;
  idiv_pkg::count_t cnt_r;
  logic             last_iter;
  logic             last_neg_r;
  logic             zero_r;
  logic             divisor_neg_r;
  logic             dividend_neg_r;

  // iterations run for IDIV_WIDTH+1 cycles, count 0..IDIV_WIDTH
  assign last_iter = (cnt_r == idiv_pkg::count_t'(`IDIV_WIDTH));

  // ------------------------------------------------------------
  // state, counter and sign flags
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r        <= idiv_pkg::IDLE;
      cnt_r          <= '0;
      last_neg_r     <= 1'b0;
      zero_r         <= 1'b0;
      divisor_neg_r  <= 1'b0;
      dividend_neg_r <= 1'b0;
    end else begin
      state_r <= state_d;
      case (state_r)
        idiv_pkg::NEG_DIVISOR: begin
          zero_r        <= zero_divisor_i;
          divisor_neg_r <= signed_div_i & a_neg_i;
        end
        idiv_pkg::NEG_DIVIDEND: begin
          dividend_neg_r <= signed_div_i & c_neg_i;
        end
        idiv_pkg::SHIFT: begin
          cnt_r      <= '0;
          last_neg_r <= 1'b0;
        end
        idiv_pkg::ITERATE: begin
          cnt_r      <= cnt_r + 1'b1;
          // sign of the partial remainder picks add or subtract next
          last_neg_r <= adder_neg_i;
        end
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------
  // step decode
  // ------------------------------------------------------------
  always_comb begin
    state_d     = state_r;
    ready_and_o = 1'b0;
    v_o         = 1'b0;
    a_sel_o     = idiv_pkg::A_SEL_ADDER;
    a_ld_o      = 1'b0;
    a_inv_o     = 1'b0;
    a_clr_n_o   = 1'b1;
    b_sel_o     = idiv_pkg::B_SEL_ADDER;
    b_ld_o      = 1'b0;
    b_inv_o     = 1'b0;
    b_clr_n_o   = 1'b1;
    c_sel_o     = idiv_pkg::C_SEL_ADDER;
    c_ld_o      = 1'b0;
    sign_ld_o   = 1'b0;
    adder_cin_o = 1'b0;

    case (state_r)
      idiv_pkg::IDLE: begin
        ready_and_o = 1'b1;
        a_sel_o     = idiv_pkg::A_SEL_DIVISOR;
        c_sel_o     = idiv_pkg::C_SEL_DIVIDEND;
        if (v_i) begin
          a_ld_o    = 1'b1;
          c_ld_o    = 1'b1;
          sign_ld_o = 1'b1;
          state_d   = idiv_pkg::NEG_DIVISOR;
        end
      end
      idiv_pkg::NEG_DIVISOR: begin
        // A <= -A, and park the dividend in B for its own negation
        a_inv_o     = 1'b1;
        b_clr_n_o   = 1'b0;
        adder_cin_o = 1'b1;
        a_ld_o      = signed_div_i & a_neg_i;
        b_sel_o     = idiv_pkg::B_SEL_C;
        b_ld_o      = 1'b1;
        state_d     = idiv_pkg::NEG_DIVIDEND;
      end
      idiv_pkg::NEG_DIVIDEND: begin
        a_clr_n_o   = 1'b0;
        b_inv_o     = 1'b1;
        adder_cin_o = 1'b1;
        c_ld_o      = signed_div_i & c_neg_i & ~zero_r;
        state_d     = idiv_pkg::SHIFT;
      end
      idiv_pkg::SHIFT: begin
        a_clr_n_o = 1'b0;
        b_clr_n_o = 1'b0;
        if (zero_r) begin
          // ~0 through the adder gives the all-ones quotient
          a_clr_n_o = 1'b1;
          a_inv_o   = 1'b1;
          c_ld_o    = 1'b1;
        end else begin
          b_sel_o = idiv_pkg::B_SEL_SHIFT;
          b_ld_o  = 1'b1;
          c_sel_o = idiv_pkg::C_SEL_SHIFT;
          c_ld_o  = 1'b1;
        end
        state_d = idiv_pkg::ITERATE;
      end
      idiv_pkg::ITERATE: begin
        // subtract on a non-negative remainder, add otherwise
        a_inv_o     = ~last_neg_r;
        adder_cin_o = ~last_neg_r;
        if (!zero_r) begin
          b_sel_o = last_iter ? idiv_pkg::B_SEL_ADDER : idiv_pkg::B_SEL_SHIFT;
          b_ld_o  = 1'b1;
          c_sel_o = idiv_pkg::C_SEL_SHIFT;
          c_ld_o  = 1'b1;
        end
        if (last_iter) begin
          state_d = idiv_pkg::REPAIR;
        end
      end
      idiv_pkg::REPAIR: begin
        // A <= B + A when the remainder went negative, else A <= B
        a_clr_n_o = last_neg_r & ~zero_r;
        a_ld_o    = 1'b1;
        b_sel_o   = idiv_pkg::B_SEL_C;
        b_ld_o    = 1'b1;
        state_d   = idiv_pkg::NEG_REM;
      end
      idiv_pkg::NEG_REM: begin
        a_inv_o     = 1'b1;
        b_clr_n_o   = 1'b0;
        adder_cin_o = 1'b1;
        a_ld_o      = dividend_neg_r & ~zero_r;
        state_d     = idiv_pkg::NEG_QUOT;
      end
      idiv_pkg::NEG_QUOT: begin
        a_clr_n_o   = 1'b0;
        b_inv_o     = 1'b1;
        adder_cin_o = 1'b1;
        c_ld_o      = (divisor_neg_r ^ dividend_neg_r) & ~zero_r;
        state_d     = idiv_pkg::DONE;
      end
      idiv_pkg::DONE: begin
        v_o = 1'b1;
        if (yumi_i) begin
          state_d = idiv_pkg::IDLE;
        end
      end
      default: begin
        state_d = idiv_pkg::IDLE;
      end
    endcase
  end

endmodule

// ==== verilog/idiv_iterative.sv ====
`timescale 1ns/1ps

module idiv_iterative (
  input  logic            clk_i,
  input  logic            rst_n_i,

  input  logic            v_i,
  output logic            ready_and_o,
  input  idiv_pkg::word_t dividend_i,
  input  idiv_pkg::word_t divisor_i,
  input  logic            signed_div_i,

  output logic            v_o,
  output idiv_pkg::word_t quotient_o,
  output idiv_pkg::word_t remainder_o,
  input  logic            yumi_i
);

  idiv_pkg::a_sel_t  a_sel;
  idiv_pkg::bc_sel_t b_sel, c_sel;
  logic a_ld, a_inv, a_clr_n;
  logic b_ld, b_inv, b_clr_n;
  logic c_ld, sign_ld, adder_cin;

  // status from the datapath
  logic zero_divisor, signed_div, adder_neg, a_neg, c_neg;

  idiv_controller u_controller (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .v_i            (v_i),
    .yumi_i         (yumi_i),
    .zero_divisor_i (zero_divisor),
    .signed_div_i   (signed_div),
    .adder_neg_i    (adder_neg),
    .a_neg_i        (a_neg),
    .c_neg_i        (c_neg),
    .ready_and_o    (ready_and_o),
    .v_o            (v_o),
    .a_sel_o        (a_sel),
    .a_ld_o         (a_ld),
    .a_inv_o        (a_inv),
    .a_clr_n_o      (a_clr_n),
    .b_sel_o        (b_sel),
    .b_ld_o         (b_ld),
    .b_inv_o        (b_inv),
    .b_clr_n_o      (b_clr_n),
    .c_sel_o        (c_sel),
    .c_ld_o         (c_ld),
    .sign_ld_o      (sign_ld),
    .adder_cin_o    (adder_cin)
  );

  idiv_datapath u_datapath (
    .clk_i          (clk_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .signed_div_i   (signed_div_i),
    .a_sel_i        (a_sel),
    .a_ld_i         (a_ld),
    .a_inv_i        (a_inv),
    .a_clr_n_i      (a_clr_n),
    .b_sel_i        (b_sel),
    .b_ld_i         (b_ld),
    .b_inv_i        (b_inv),
    .b_clr_n_i      (b_clr_n),
    .c_sel_i        (c_sel),
    .c_ld_i         (c_ld),
    .sign_ld_i      (sign_ld),
    .adder_cin_i    (adder_cin),
    .zero_divisor_o (zero_divisor),
    .signed_div_o   (signed_div),
    .adder_neg_o    (adder_neg),
    .a_neg_o        (a_neg),
    .c_neg_o        (c_neg),
    .quotient_o     (quotient_o),
    .remainder_o    (remainder_o)
  );

endmodule

// ==== test/idiv_asserts.sv ====
`timescale 1ns/1ps

module idiv_asserts (
  input logic            clk_i,
  input logic            rst_n_i,
  input logic            ready_i,
  input logic            out_v_i,
  input logic            yumi_i,
  input idiv_pkg::word_t quotient_i,
  input idiv_pkg::word_t remainder_i
);

  int unsigned fail_count = 0;

  // the divider is either idle or holding a result, never both
  ready_valid_excl: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(ready_i && out_v_i)
  ) else begin
    $error("ready_and_o and v_o are high in the same cycle");
    fail_count++;
  end

  // a waiting result keeps v_o and its value until the consumer takes it
  result_held: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    out_v_i && !yumi_i |=> out_v_i && $stable(quotient_i) && $stable(remainder_i)
  ) else begin
    $error("v_o or the result changed before yumi_i");
    fail_count++;
  end

  ready_after_reset: assert property (
    @(posedge clk_i) $rose(rst_n_i) |-> ready_i
  ) else begin
    $error("ready_and_o is not high once reset is released");
    fail_count++;
  end

endmodule

// ==== test/idiv_tb.sv ====
`timescale 1ns/1ps
`include "idiv_defs.svh"

module idiv_tb;

  localparam int W          = `IDIV_WIDTH;
  localparam int LATENCY    = W + 7;
  localparam int CLK_PERIOD = 20;
  localparam int MAX_OPS    = 200;
  localparam int OP_CYCLES  = 60;

  logic            clk;
  logic            rst_n;
  logic            in_v;
  logic            ready;
  idiv_pkg::word_t dividend;
  idiv_pkg::word_t divisor;
  logic            signed_div;
  logic            out_v;
  idiv_pkg::word_t quotient;
  idiv_pkg::word_t remainder;
  logic            yumi;

  idiv_iterative u_idiv_iterative (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .v_i          (in_v),
    .ready_and_o  (ready),
    .dividend_i   (dividend),
    .divisor_i    (divisor),
    .signed_div_i (signed_div),
    .v_o          (out_v),
    .quotient_o   (quotient),
    .remainder_o  (remainder),
    .yumi_i       (yumi)
  );

  bind idiv_iterative idiv_asserts u_asserts (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ready_i     (ready_and_o),
    .out_v_i     (v_o),
    .yumi_i      (yumi_i),
    .quotient_i  (quotient_o),
    .remainder_i (remainder_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // budget of 60 cycles for each of up to 200 operations
  initial begin
    #(MAX_OPS * OP_CYCLES * CLK_PERIOD);
    $display("timeout: the divider stopped responding before the tests finished");
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

  // ------------------------------------------------------------
  // checks and reference model
  // ------------------------------------------------------------
  task automatic compare_word(input string name, input idiv_pkg::word_t expected,
                              input idiv_pkg::word_t actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Done: errors found");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic compare_cycles(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("FAILED %s: expected %0d cycles, actual %0d cycles", name, expected, actual);
      $display("Done: errors found");
      $fatal(1, "latency mismatch");
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    if (cond !== 1'b1) begin
      $display("%s", what);
      $display("Done: errors found");
      $fatal(1, "handshake check failed");
    end
  endtask

  // floor division when unsigned, truncation toward zero when signed
  task automatic model_div(input idiv_pkg::word_t a, input idiv_pkg::word_t b,
                           input logic sgn,
                           output idiv_pkg::word_t q, output idiv_pkg::word_t r);
    logic signed [W-1:0] sa;
    logic signed [W-1:0] sb;
    sa = a;
    sb = b;
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (sgn && a == {1'b1, {(W-1){1'b0}}} && b == '1) begin
      q = a;
      r = '0;
    end else if (sgn) begin
      q = sa / sb;
      r = sa % sb;
    end else begin
      q = a / b;
      r = a % b;
    end
  endtask

  // divisor magnitudes spread over all bit lengths
  function automatic idiv_pkg::word_t random_divisor();
    return idiv_pkg::word_t'($urandom) >> ($urandom % W);
  endfunction

  // ------------------------------------------------------------
  // handshake helpers
  // ------------------------------------------------------------
  task automatic start_op(input idiv_pkg::word_t a, input idiv_pkg::word_t b,
                          input logic sgn);
    dividend   = a;
    divisor    = b;
    signed_div = sgn;
    in_v       = 1'b1;
    while (ready !== 1'b1) begin
      @(posedge clk);
      #2;
    end
    // this edge accepts the request
    @(posedge clk);
    #2;
    in_v = 1'b0;
    expect_true(~ready, "ready_and_o stayed high after a request was accepted");
  endtask

  task automatic wait_result(output int cycles);
    cycles = 0;
    while (out_v !== 1'b1) begin
      @(posedge clk);
      #2;
      cycles++;
    end
  endtask

  task automatic consume();
    yumi = 1'b1;
    @(posedge clk);
    #2;
    yumi = 1'b0;
  endtask

  task automatic run_op(input string name, input idiv_pkg::word_t a,
                        input idiv_pkg::word_t b, input logic sgn);
    idiv_pkg::word_t exp_q;
    idiv_pkg::word_t exp_r;
    int              cycles;
    model_div(a, b, sgn, exp_q, exp_r);
    start_op(a, b, sgn);
    wait_result(cycles);
    compare_cycles({name, " latency"}, LATENCY, cycles);
    compare_word({name, " quotient"}, exp_q, quotient);
    compare_word({name, " remainder"}, exp_r, remainder);
    consume();
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic test_latency();
    idiv_pkg::word_t exp_q;
    idiv_pkg::word_t exp_r;
    int              cycles;
    expect_true(ready, "test_latency: ready_and_o was not high after reset");
    expect_true(~out_v, "test_latency: v_o was high after reset");
    model_div('d1000, 'd7, 1'b0, exp_q, exp_r);
    start_op('d1000, 'd7, 1'b0);
    wait_result(cycles);
    compare_cycles("test_latency", LATENCY, cycles);
    compare_word("test_latency quotient", exp_q, quotient);
    compare_word("test_latency remainder", exp_r, remainder);
    consume();
    expect_true(ready, "test_latency: ready_and_o did not return on the edge after yumi_i");
  endtask

  task automatic test_unsigned();
    idiv_pkg::word_t a;
    idiv_pkg::word_t b;
    run_op("test_unsigned one", 'd1, 'd1, 1'b0);
    run_op("test_unsigned all ones", '1, 'd1, 1'b0);
    run_op("test_unsigned all ones both", '1, '1, 1'b0);
    run_op("test_unsigned small dividend", 'd5, 'd7, 1'b0);
    run_op("test_unsigned top bit", {1'b1, {(W-1){1'b0}}}, '1, 1'b0);
    repeat (100) begin
      a = $urandom;
      b = random_divisor();
      run_op("test_unsigned random", a, b, 1'b0);
    end
  endtask

  task automatic test_signed();
    idiv_pkg::word_t ma;
    idiv_pkg::word_t mb;
    run_op("test_signed neg by pos", idiv_pkg::word_t'(-7), 'd2, 1'b1);
    run_op("test_signed pos by neg", 'd7, idiv_pkg::word_t'(-2), 1'b1);
    run_op("test_signed neg by neg", idiv_pkg::word_t'(-7), idiv_pkg::word_t'(-2), 1'b1);
    // bit 0 and bit 1 of i walk through the four sign combinations
    for (int i = 0; i < 40; i++) begin
      ma = idiv_pkg::word_t'($urandom) >> 1;
      mb = random_divisor() >> 1;
      run_op("test_signed random", i[0] ? -ma : ma, i[1] ? -mb : mb, 1'b1);
    end
  endtask

  task automatic test_special();
    run_op("test_special zero divisor unsigned", 'h1234_5678, '0, 1'b0);
    run_op("test_special zero divisor signed", 'hf000_0001, '0, 1'b1);
    run_op("test_special overflow", {1'b1, {(W-1){1'b0}}}, '1, 1'b1);
  endtask

  task automatic test_backpressure();
    idiv_pkg::word_t a1;
    idiv_pkg::word_t b1;
    idiv_pkg::word_t a2;
    idiv_pkg::word_t b2;
    idiv_pkg::word_t exp_q;
    idiv_pkg::word_t exp_r;
    int              cycles;
    int              hold;
    repeat (3) begin
      a1   = $urandom;
      b1   = random_divisor();
      a2   = $urandom;
      b2   = random_divisor();
      hold = 5 + int'($urandom % 26);
      model_div(a1, b1, 1'b0, exp_q, exp_r);
      start_op(a1, b1, 1'b0);
      wait_result(cycles);
      compare_word("test_backpressure first quotient", exp_q, quotient);
      compare_word("test_backpressure first remainder", exp_r, remainder);
      // next request waits on the input while the result is not taken
      dividend   = a2;
      divisor    = b2;
      signed_div = 1'b1;
      in_v       = 1'b1;
      repeat (hold) begin
        @(posedge clk);
        #2;
        compare_word("test_backpressure held quotient", exp_q, quotient);
        compare_word("test_backpressure held remainder", exp_r, remainder);
        expect_true(out_v, "test_backpressure: v_o dropped while yumi_i was low");
        expect_true(~ready, "test_backpressure: ready_and_o rose while a result waited");
      end
      consume();
      model_div(a2, b2, 1'b1, exp_q, exp_r);
      start_op(a2, b2, 1'b1);
      wait_result(cycles);
      compare_word("test_backpressure second quotient", exp_q, quotient);
      compare_word("test_backpressure second remainder", exp_r, remainder);
      consume();
    end
  endtask

  initial begin
    void'($urandom(32'hcab1eb3c));
    rst_n      = 1'b0;
    in_v       = 1'b0;
    dividend   = '0;
    divisor    = '0;
    signed_div = 1'b0;
    yumi       = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_latency();
    test_unsigned();
    test_signed();
    test_special();
    test_backpressure();

    repeat (2) @(posedge clk);
    if (u_idiv_iterative.u_asserts.fail_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("%0d handshake assertion failures were reported",
               u_idiv_iterative.u_asserts.fail_count);
      $display("Done: errors found");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/idiv_pkg.sv
verilog/idiv_datapath.sv
verilog/idiv_controller.sv
verilog/idiv_iterative.sv
test/idiv_asserts.sv
test/idiv_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the divider testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module idiv_tb \
  -f list.f --Mdir obj_dir -o idiv_sim \
  && ./obj_dir/idiv_sim +verilator+error+limit+100 > sim.log 2>&1 \
  || echo "build or simulation step returned an error"

grep -qx "Done: no errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
